// File: files.f
dir_pkg.sv
dir_state_select.sv
dir_protocol_rom.sv
dir_entry_update.sv
dir_message_gen.sv
dir_stage3.sv
tb_clock_gen.sv
dir_stage3_tb.sv

// File: Makefile
TOP := dir_stage3_tb
SOURCES := $(shell cat files.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): files.f $(SOURCES)
	verilator --binary --timing --top-module $(TOP) -f files.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Test completed successfully$$"

clean:
	rm -rf obj_dir

// File: dir_stage3_tb.sv
// Directory stage 3 testbench
`default_nettype none

module dir_stage3_tb import dir_pkg::*; ();

	localparam int HOME_TILE = 2;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_MESSAGES = 2000;

	logic          clk;
	logic          reset;
	logic          message_valid;
	dir_message_t  message;
	logic          tshr_hit;
	tshr_idx_t     tshr_index;
	dir_entry_t    tshr_entry;
	logic          cache_hit;
	dir_entry_t    cache_entry;
	line_t         cache_data;
	way_t          cache_way;
	tshr_idx_t     tshr_empty_index;
	tshr_update_t  tshr_update;
	cache_update_t cache_update;
	fwd_msg_t      fwd;
	response_t     response;

	// Expected outputs for the message currently in the register stage
	tshr_update_t  exp_tshr;
	cache_update_t exp_cache;
	fwd_msg_t      exp_fwd;
	response_t     exp_resp;

	int tshr_alloc_seen;
	int tshr_dealloc_seen;
	int inv_seen;
	int fwd_gets_seen;
	int put_ack_seen;
	int wipe_seen;

	tb_clock_gen #(
		.PERIOD(40)
	) u_clock_gen (
		.clk(clk)
	);

	dir_stage3 #(
		.HOME_TILE(HOME_TILE)
	) DUT (
		.clk             (clk),
		.reset           (reset),
		.message_valid   (message_valid),
		.message         (message),
		.tshr_hit        (tshr_hit),
		.tshr_index      (tshr_index),
		.tshr_entry      (tshr_entry),
		.cache_hit       (cache_hit),
		.cache_entry     (cache_entry),
		.cache_data      (cache_data),
		.cache_way       (cache_way),
		.tshr_empty_index(tshr_empty_index),
		.tshr_update     (tshr_update),
		.cache_update    (cache_update),
		.fwd             (fwd),
		.response        (response)
	);

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
			$display("Test failed");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	// Payload fields only carry meaning while their enable or valid is set
	task automatic check_outputs;
		check_value(64'(tshr_update.enable), 64'(exp_tshr.enable), "tshr_update.enable");
		if (exp_tshr.enable) begin
			check_value(64'(tshr_update), 64'(exp_tshr), "tshr_update");
		end
		check_value(64'(cache_update.enable), 64'(exp_cache.enable), "cache_update.enable");
		if (exp_cache.enable) begin
			check_value(64'(cache_update), 64'(exp_cache), "cache_update");
		end
		check_value(64'(fwd.valid), 64'(exp_fwd.valid), "fwd.valid");
		if (exp_fwd.valid) begin
			check_value(64'(fwd), 64'(exp_fwd), "fwd");
		end
		check_value(64'(response.valid), 64'(exp_resp.valid), "response.valid");
		if (exp_resp.valid) begin
			check_value(64'(response), 64'(exp_resp), "response");
		end
	endtask

	function automatic logic outputs_busy();
		return tshr_update.enable !== 1'b0 || cache_update.enable !== 1'b0
			|| fwd.valid !== 1'b0 || response.valid !== 1'b0;
	endfunction

	task automatic wait_outputs_idle(input int limit, output int cycles);
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (outputs_busy() && cycles < limit);
		if (outputs_busy()) begin
			$display("Outputs stayed active for %0d cycles while reset was held", limit);
			$display("Test failed");
			$fatal(1, "Reset did not clear the outputs");
		end
	endtask

	task automatic drive_idle;
		message_valid = 1'b0;
		message = '0;
		tshr_hit = 1'b0;
		tshr_index = '0;
		tshr_entry = '0;
		cache_hit = 1'b0;
		cache_entry = '0;
		cache_data = '0;
		cache_way = '0;
		tshr_empty_index = '0;
	endtask

	// Lookup results agree with the chosen directory state
	task automatic drive_random;
		dir_state_t st;
		dir_entry_t entry;
		st = dir_state_t'($urandom_range(3, 0));
		message_valid = ($urandom_range(7, 0) != 0);
		message.msg_type = dir_msg_t'($urandom_range(4, 0));
		message.address = addr_t'($urandom);
		message.data = $urandom;
		message.source = tile_id_t'($urandom_range(TILE_COUNT - 1, 0));
		entry.state = st;
		entry.owner = tile_id_t'($urandom_range(TILE_COUNT - 1, 0));
		entry.sharers = '0;
		if (st == ST_S || st == ST_SD) begin
			entry.sharers = tile_mask_t'($urandom_range((1 << TILE_COUNT) - 1, 1));
		end
		// Half the time the owner or a sharer asks, so puts hit both table rows
		if (st == ST_M && $urandom_range(1, 0) == 1) begin
			message.source = entry.owner;
		end
		if (st == ST_S && $urandom_range(1, 0) == 1) begin
			entry.sharers[message.source] = 1'b1;
		end
		tshr_hit = (st == ST_SD);
		cache_hit = (st == ST_S || st == ST_M) || (st == ST_SD && $urandom_range(1, 0) == 1);
		tshr_entry = (st == ST_SD) ? entry : dir_entry_t'(8'($urandom));
		cache_entry = (st == ST_S || st == ST_M) ? entry : dir_entry_t'(8'($urandom));
		tshr_index = tshr_idx_t'($urandom_range(TSHR_ENTRIES - 1, 0));
		tshr_empty_index = tshr_idx_t'($urandom_range(TSHR_ENTRIES - 1, 0));
		cache_way = way_t'($urandom_range(3, 0));
		cache_data = $urandom;
	endtask

	// Reference model of the MSI table and the TSHR and cache update rules
	task automatic compute_expected;
		dir_entry_t cur;
		dir_state_t ns;
		tile_mask_t req_m;
		tile_mask_t own_m;
		tile_mask_t sh;
		tile_id_t   own;
		fwd_type_t  ft;
		resp_type_t rt;
		logic       from_cache;
		logic       add_req, add_own, clr, rem, set_own, clr_own, store, inval;
		logic       changed, cur_stable, next_stable;
		logic       t_alloc, t_upd, t_dealloc, c_upd, c_alloc, c_dealloc;
		if (tshr_hit) begin
			cur = tshr_entry;
		end else if (cache_hit) begin
			cur = cache_entry;
		end else begin
			cur.state = ST_I;
			cur.sharers = '0;
			cur.owner = tile_id_t'(HOME_TILE);
		end
		from_cache = !tshr_hit && cache_hit;
		req_m = '0;
		req_m[message.source] = 1'b1;
		own_m = '0;
		own_m[cur.owner] = 1'b1;
		ns = cur.state;
		{add_req, add_own, clr, rem, set_own, clr_own, store, inval} = '0;
		ft = FWD_NONE;
		rt = RESP_NONE;
		if (message_valid) begin
			case ({cur.state, message.msg_type})
				{ST_I, GETS}: begin
					ns = ST_S;
					add_req = 1'b1;
					rt = RESP_DATA;
				end
				{ST_I, GETM}: begin
					ns = ST_M;
					set_own = 1'b1;
					rt = RESP_DATA;
				end
				{ST_S, GETS}: begin
					add_req = 1'b1;
					rt = RESP_DATA;
				end
				{ST_S, GETM}: begin
					ns = ST_M;
					ft = FWD_INV;
					clr = 1'b1;
					set_own = 1'b1;
					rt = RESP_DATA;
				end
				{ST_S, PUTS}: begin
					if ($countones(cur.sharers) == 1) begin
						ns = ST_I;
						clr = 1'b1;
						inval = 1'b1;
					end else begin
						rem = 1'b1;
					end
					rt = RESP_PUT_ACK;
				end
				{ST_M, GETS}: begin
					if (message.source != cur.owner) begin
						ns = ST_SD;
						ft = FWD_GETS;
						add_req = 1'b1;
						add_own = 1'b1;
					end
				end
				{ST_M, GETM}: begin
					if (message.source != cur.owner) begin
						ft = FWD_GETM;
						set_own = 1'b1;
					end
				end
				{ST_M, PUTM}: begin
					if (message.source == cur.owner) begin
						ns = ST_I;
						store = 1'b1;
						clr_own = 1'b1;
						inval = 1'b1;
					end
					rt = RESP_PUT_ACK;
				end
				{ST_SD, DATA}: begin
					ns = ST_S;
					store = 1'b1;
				end
				default: begin
				end
			endcase
		end

		sh = cur.sharers;
		if (add_req) sh = sh | req_m;
		if (add_own) sh = sh | own_m;
		if (clr) sh = '0;
		if (rem) sh = sh & ~req_m;
		own = clr_own ? tile_id_t'(HOME_TILE) : (set_own ? message.source : cur.owner);
		changed = (ns != cur.state) || add_req || add_own || clr || rem || set_own || clr_own;
		cur_stable = (cur.state != ST_SD);
		next_stable = (ns != ST_SD);
		t_alloc = cur_stable && !next_stable;
		t_upd = !cur_stable && !next_stable && changed;
		t_dealloc = !cur_stable && next_stable;
		c_upd = from_cache && cur_stable && next_stable && (changed || store);
		c_dealloc = t_alloc && from_cache;
		c_alloc = next_stable && (changed || store) && !(t_dealloc && inval) && !c_upd;

		exp_tshr.enable = t_alloc || t_upd || t_dealloc;
		exp_tshr.index = t_alloc ? tshr_empty_index : tshr_index;
		exp_tshr.valid = t_alloc || t_upd;
		exp_tshr.state = ns;
		exp_tshr.address = message.address;
		exp_tshr.sharers = sh;
		exp_tshr.owner = own;

		exp_cache.enable = c_upd || c_alloc || c_dealloc;
		exp_cache.valid = !inval;
		exp_cache.set = message.address[7:2];
		exp_cache.way = cache_way;
		exp_cache.tag = message.address[15:8];
		exp_cache.state = ns;
		exp_cache.sharers = sh;
		exp_cache.owner = own;
		exp_cache.data = store ? message.data : cache_data;

		exp_fwd.valid = (ft != FWD_NONE);
		exp_fwd.fwd_type = ft;
		exp_fwd.source = message.source;
		exp_fwd.address = message.address;
		exp_fwd.destinations = (ft == FWD_INV) ? cur.sharers : own_m;

		exp_resp.valid = (rt != RESP_NONE);
		exp_resp.resp_type = rt;
		exp_resp.source = message.source;
		exp_resp.address = message.address;
		exp_resp.data = from_cache ? cache_data : message.data;
		exp_resp.sharers_count = sharer_count_t'($countones(cur.sharers));
		exp_resp.has_data = (rt == RESP_DATA);
		exp_resp.destinations = req_m;

		if (t_alloc) tshr_alloc_seen++;
		if (t_dealloc) tshr_dealloc_seen++;
		if (ft == FWD_INV) inv_seen++;
		if (ft == FWD_GETS) fwd_gets_seen++;
		if (rt == RESP_PUT_ACK) put_ack_seen++;
		if (exp_cache.enable && inval) wipe_seen++;
	endtask

	initial begin
		int waited;
		void'($urandom(19018));
		tshr_alloc_seen = 0;
		tshr_dealloc_seen = 0;
		inv_seen = 0;
		fwd_gets_seen = 0;
		put_ack_seen = 0;
		wipe_seen = 0;
		reset = 1'b1;
		drive_idle();
		compute_expected();
		wait_outputs_idle(RESET_CYCLES, waited);
		for (int i = waited; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			#1;
			check_outputs();
		end
		#1;
		reset = 1'b0;

		for (int n = 0; n < NUM_MESSAGES; n++) begin
			@(posedge clk);
			#1;
			check_outputs();
			#1;
			drive_random();
			compute_expected();
		end
		// The last message leaves the register stage one edge later
		@(posedge clk);
		#1;
		check_outputs();

		if (tshr_alloc_seen == 0 || tshr_dealloc_seen == 0 || inv_seen == 0
			|| fwd_gets_seen == 0 || put_ack_seen == 0 || wipe_seen == 0) begin
			$display("Some protocol transitions were never exercised by the stimulus");
			$display("Test failed");
			$fatal(1, "Incomplete stimulus");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// Testbench clock source
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2);
			clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// File: dir_stage3.sv
// Directory controller execution stage
`default_nettype none

module dir_stage3 import dir_pkg::*; #(
	parameter int HOME_TILE = 0
) (
	input  logic          clk,
	input  logic          reset,
	input  logic          message_valid,
	input  dir_message_t  message,
	input  logic          tshr_hit,
	input  tshr_idx_t     tshr_index,
	input  dir_entry_t    tshr_entry,
	input  logic          cache_hit,
	input  dir_entry_t    cache_entry,
	input  line_t         cache_data,
	input  way_t          cache_way,
	input  tshr_idx_t     tshr_empty_index,
	output tshr_update_t  tshr_update,
	output cache_update_t cache_update,
	output fwd_msg_t      fwd,
	output response_t     response
);

	dir_entry_t    current_entry;
	entry_source_t entry_source;
	tile_mask_t    requestor_oh;
	tile_mask_t    owner_oh;
	sharer_count_t sharer_count;
	logic          is_from_owner;
	logic          one_sharer;
	rom_action_t   action;

	dir_state_select #(
		.HOME_TILE(HOME_TILE)
	) u_state_select (
		.message      (message),
		.tshr_hit     (tshr_hit),
		.tshr_entry   (tshr_entry),
		.cache_hit    (cache_hit),
		.cache_entry  (cache_entry),
		.current_entry(current_entry),
		.entry_source (entry_source),
		.requestor_oh (requestor_oh),
		.owner_oh     (owner_oh),
		.sharer_count (sharer_count),
		.is_from_owner(is_from_owner),
		.one_sharer   (one_sharer)
	);

	// Only the ROM looks at message_valid
	dir_protocol_rom u_protocol_rom (
		.message_valid(message_valid),
		.state        (current_entry.state),
		.request      (message.msg_type),
		.is_from_owner(is_from_owner),
		.one_sharer   (one_sharer),
		.action       (action)
	);

	dir_entry_update #(
		.HOME_TILE(HOME_TILE)
	) u_entry_update (
		.clk             (clk),
		.reset           (reset),
		.message         (message),
		.current_entry   (current_entry),
		.entry_source    (entry_source),
		.requestor_oh    (requestor_oh),
		.owner_oh        (owner_oh),
		.action          (action),
		.tshr_index      (tshr_index),
		.tshr_empty_index(tshr_empty_index),
		.cache_data      (cache_data),
		.cache_way       (cache_way),
		.tshr_update     (tshr_update),
		.cache_update    (cache_update)
	);

	dir_message_gen u_message_gen (
		.clk          (clk),
		.reset        (reset),
		.message      (message),
		.current_entry(current_entry),
		.entry_source (entry_source),
		.requestor_oh (requestor_oh),
		.owner_oh     (owner_oh),
		.sharer_count (sharer_count),
		.action       (action),
		.cache_data   (cache_data),
		.fwd          (fwd),
		.response     (response)
	);

endmodule

`default_nettype wire

// File: dir_message_gen.sv
// Forwarded request and response generation
`default_nettype none

module dir_message_gen import dir_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  dir_message_t  message,
	input  dir_entry_t    current_entry,
	input  entry_source_t entry_source,
	input  tile_mask_t    requestor_oh,
	input  tile_mask_t    owner_oh,
	input  sharer_count_t sharer_count,
	input  rom_action_t   action,
	input  line_t         cache_data,
	output fwd_msg_t      fwd,
	output response_t     response
);

	fwd_msg_t  fwd_next;
	response_t resp_next;
	fwd_msg_t  fwd_q;
	response_t resp_q;
	logic      fwd_valid_q;
	logic      resp_valid_q;

	function automatic tile_mask_t pick_dest(dest_sel_t sel, tile_mask_t req_mask,
		tile_mask_t own_mask, tile_mask_t sharers);
		case (sel)
			DEST_OWNER:   return own_mask;
			DEST_SHARERS: return sharers;
			default:      return req_mask;
		endcase
	endfunction

	always_comb begin
		fwd_next.valid = action.fwd_send;
		fwd_next.fwd_type = action.fwd_type;
		fwd_next.source = message.source;
		fwd_next.address = message.address;
		fwd_next.destinations = pick_dest(action.fwd_dest, requestor_oh, owner_oh,
			current_entry.sharers);
	end

	always_comb begin
		resp_next.valid = action.resp_send;
		resp_next.resp_type = action.resp_type;
		resp_next.source = message.source;
		resp_next.address = message.address;
		// A directory cache hit supplies the line, otherwise the message carries it
		resp_next.data = (entry_source == SRC_CACHE) ? cache_data : message.data;
		resp_next.sharers_count = sharer_count;
		resp_next.has_data = action.resp_has_data;
		resp_next.destinations = pick_dest(action.resp_dest, requestor_oh, owner_oh,
			current_entry.sharers);
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			fwd_valid_q <= 1'b0;
			resp_valid_q <= 1'b0;
		end else begin
			fwd_valid_q <= fwd_next.valid;
			resp_valid_q <= resp_next.valid;
		end
	end

	always_ff @(posedge clk) begin
		fwd_q <= fwd_next;
		resp_q <= resp_next;
	end

	always_comb begin
		fwd = fwd_q;
		fwd.valid = fwd_valid_q;
		response = resp_q;
		response.valid = resp_valid_q;
	end

endmodule

`default_nettype wire

// File: dir_entry_update.sv
// TSHR and directory cache update
`default_nettype none

module dir_entry_update import dir_pkg::*; #(
	parameter int HOME_TILE = 0
) (
	input  logic          clk,
	input  logic          reset,
	input  dir_message_t  message,
	input  dir_entry_t    current_entry,
	input  entry_source_t entry_source,
	input  tile_mask_t    requestor_oh,
	input  tile_mask_t    owner_oh,
	input  rom_action_t   action,
	input  tshr_idx_t     tshr_index,
	input  tshr_idx_t     tshr_empty_index,
	input  line_t         cache_data,
	input  way_t          cache_way,
	output tshr_update_t  tshr_update,
	output cache_update_t cache_update
);

	tile_mask_t    next_sharers;
	tile_id_t      next_owner;
	line_t         next_data;
	logic          info_changed;
	logic          tshr_allocate;
	logic          tshr_modify;
	logic          tshr_deallocate;
	logic          cache_modify;
	logic          cache_allocate;
	logic          cache_deallocate;
	tshr_update_t  tshr_next;
	cache_update_t cache_next;
	tshr_update_t  tshr_q;
	cache_update_t cache_q;
	logic          tshr_enable_q;
	logic          cache_enable_q;

	// Additions first, then clear and remove win over them
	assign next_sharers = (current_entry.sharers
		| ({TILE_COUNT{action.sharers_add_requestor}} & requestor_oh)
		| ({TILE_COUNT{action.sharers_add_owner}} & owner_oh))
		& ~{TILE_COUNT{action.sharers_clear}}
		& ~({TILE_COUNT{action.sharers_remove_requestor}} & requestor_oh);

	assign next_owner = action.owner_clear ? tile_id_t'(HOME_TILE)
		: action.owner_set_requestor ? message.source : current_entry.owner;

	assign next_data = action.store_data ? message.data : cache_data;

	assign info_changed = (current_entry.state != action.next_state)
		| action.sharers_add_requestor | action.sharers_add_owner
		| action.sharers_clear | action.sharers_remove_requestor
		| action.owner_set_requestor | action.owner_clear;

	// TSHR tracks lines only while they sit in a transient state
	assign tshr_allocate = action.current_stable & ~action.next_stable;
	assign tshr_modify = ~action.current_stable & ~action.next_stable & info_changed;
	assign tshr_deallocate = ~action.current_stable & action.next_stable;

	assign cache_modify = (entry_source == SRC_CACHE) & action.current_stable
		& action.next_stable & (info_changed | action.store_data);
	assign cache_deallocate = tshr_allocate & (entry_source == SRC_CACHE);
	assign cache_allocate = action.next_stable & (info_changed | action.store_data)
		& ~(tshr_deallocate & action.invalidate_way) & ~cache_modify;

	always_comb begin
		tshr_next.enable = tshr_allocate | tshr_modify | tshr_deallocate;
		tshr_next.index = tshr_allocate ? tshr_empty_index : tshr_index;
		tshr_next.valid = tshr_allocate | tshr_modify;
		tshr_next.state = action.next_state;
		tshr_next.address = message.address;
		tshr_next.sharers = next_sharers;
		tshr_next.owner = next_owner;
	end

	always_comb begin
		cache_next.enable = cache_allocate | cache_modify | cache_deallocate;
		cache_next.valid = ~action.invalidate_way;
		cache_next.set = addr_set(message.address);
		cache_next.way = cache_way;
		cache_next.tag = addr_tag(message.address);
		cache_next.state = action.next_state;
		cache_next.sharers = next_sharers;
		cache_next.owner = next_owner;
		cache_next.data = next_data;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tshr_enable_q <= 1'b0;
			cache_enable_q <= 1'b0;
		end else begin
			tshr_enable_q <= tshr_next.enable;
			cache_enable_q <= cache_next.enable;
		end
	end

	always_ff @(posedge clk) begin
		tshr_q <= tshr_next;
		cache_q <= cache_next;
	end

	// Enables come from the reset flops, the rest from the payload flops
	always_comb begin
		tshr_update = tshr_q;
		tshr_update.enable = tshr_enable_q;
		cache_update = cache_q;
		cache_update.enable = cache_enable_q;
	end

endmodule

`default_nettype wire

// File: dir_protocol_rom.sv
// MSI directory protocol table
`default_nettype none

module dir_protocol_rom import dir_pkg::*; (
	input  logic        message_valid,
	input  dir_state_t  state,
	input  dir_msg_t    request,
	input  logic        is_from_owner,
	input  logic        one_sharer,
	output rom_action_t action
);

	always_comb begin
		// Default row keeps the state and issues nothing
		action = '0;
		action.next_state = state;
		action.fwd_type = FWD_NONE;
		action.fwd_dest = DEST_REQUESTOR;
		action.resp_type = RESP_NONE;
		action.resp_dest = DEST_REQUESTOR;

		if (message_valid) begin
			case (state)
				ST_I: begin
					case (request)
						GETS: begin
							action.next_state = ST_S;
							action.sharers_add_requestor = 1'b1;
							action.resp_send = 1'b1;
							action.resp_type = RESP_DATA;
							action.resp_has_data = 1'b1;
						end
						GETM: begin
							action.next_state = ST_M;
							action.owner_set_requestor = 1'b1;
							action.resp_send = 1'b1;
							action.resp_type = RESP_DATA;
							action.resp_has_data = 1'b1;
						end
						default: begin
						end
					endcase
				end
				ST_S: begin
					case (request)
						GETS: begin
							action.sharers_add_requestor = 1'b1;
							action.resp_send = 1'b1;
							action.resp_type = RESP_DATA;
							action.resp_has_data = 1'b1;
						end
						GETM: begin
							// Every current sharer loses its copy
							action.next_state = ST_M;
							action.fwd_send = 1'b1;
							action.fwd_type = FWD_INV;
							action.fwd_dest = DEST_SHARERS;
							action.sharers_clear = 1'b1;
							action.owner_set_requestor = 1'b1;
							action.resp_send = 1'b1;
							action.resp_type = RESP_DATA;
							action.resp_has_data = 1'b1;
						end
						PUTS: begin
							if (one_sharer) begin
								action.next_state = ST_I;
								action.sharers_clear = 1'b1;
								action.invalidate_way = 1'b1;
							end else begin
								action.sharers_remove_requestor = 1'b1;
							end
							action.resp_send = 1'b1;
							action.resp_type = RESP_PUT_ACK;
						end
						default: begin
						end
					endcase
				end
				ST_M: begin
					case (request)
						GETS: begin
							if (!is_from_owner) begin
								// Owner keeps a shared copy once it has supplied the data
								action.next_state = ST_SD;
								action.fwd_send = 1'b1;
								action.fwd_type = FWD_GETS;
								action.fwd_dest = DEST_OWNER;
								action.sharers_add_requestor = 1'b1;
								action.sharers_add_owner = 1'b1;
							end
						end
						GETM: begin
							if (!is_from_owner) begin
								action.fwd_send = 1'b1;
								action.fwd_type = FWD_GETM;
								action.fwd_dest = DEST_OWNER;
								action.owner_set_requestor = 1'b1;
							end
						end
						PUTM: begin
							if (is_from_owner) begin
								action.next_state = ST_I;
								action.store_data = 1'b1;
								action.owner_clear = 1'b1;
								action.invalidate_way = 1'b1;
							end
							action.resp_send = 1'b1;
							action.resp_type = RESP_PUT_ACK;
						end
						default: begin
						end
					endcase
				end
				ST_SD: begin
					if (request == DATA) begin
						action.next_state = ST_S;
						action.store_data = 1'b1;
					end
				end
				default: begin
				end
			endcase
		end

		action.current_stable = state != ST_SD;
		action.next_stable = action.next_state != ST_SD;
	end

endmodule

`default_nettype wire

// File: dir_state_select.sv
// Current directory entry selection
`default_nettype none

module dir_state_select import dir_pkg::*; #(
	parameter int HOME_TILE = 0
) (
	input  dir_message_t  message,
	input  logic          tshr_hit,
	input  dir_entry_t    tshr_entry,
	input  logic          cache_hit,
	input  dir_entry_t    cache_entry,
	output dir_entry_t    current_entry,
	output entry_source_t entry_source,
	output tile_mask_t    requestor_oh,
	output tile_mask_t    owner_oh,
	output sharer_count_t sharer_count,
	output logic          is_from_owner,
	output logic          one_sharer
);

	// An open TSHR entry holds newer information than the cache line
	always_comb begin
		if (tshr_hit) begin
			current_entry = tshr_entry;
			entry_source = SRC_TSHR;
		end else if (cache_hit) begin
			current_entry = cache_entry;
			entry_source = SRC_CACHE;
		end else begin
			// Untracked lines behave as invalid and owned by the home tile
			current_entry.state = ST_I;
			current_entry.sharers = '0;
			current_entry.owner = tile_id_t'(HOME_TILE);
			entry_source = SRC_NONE;
		end
	end

	assign requestor_oh = tile_mask_t'(1) << message.source;
	assign owner_oh = tile_mask_t'(1) << current_entry.owner;

	always_comb begin
		sharer_count = '0;
		for (int i = 0; i < TILE_COUNT; i++) begin
			sharer_count = sharer_count + sharer_count_t'(current_entry.sharers[i]);
		end
	end

	assign is_from_owner = message.source == current_entry.owner;
	assign one_sharer = sharer_count == sharer_count_t'(1);

endmodule

`default_nettype wire

// File: dir_pkg.sv
// Directory stage 3 definitions
`default_nettype none

package dir_pkg;

	localparam int TILE_COUNT = 4;
	localparam int TSHR_ENTRIES = 4;

	// Line address layout is tag, set, offset from MSB to LSB
	localparam int ADDR_TAG_BITS = 8;
	localparam int ADDR_SET_BITS = 6;
	localparam int ADDR_OFFSET_BITS = 2;

	typedef logic [$clog2(TILE_COUNT) - 1:0] tile_id_t;
	typedef logic [TILE_COUNT - 1:0] tile_mask_t;
	typedef logic [$clog2(TILE_COUNT + 1) - 1:0] sharer_count_t;
	typedef logic [ADDR_TAG_BITS + ADDR_SET_BITS + ADDR_OFFSET_BITS - 1:0] addr_t;
	typedef logic [ADDR_SET_BITS - 1:0] set_t;
	typedef logic [ADDR_TAG_BITS - 1:0] tag_t;
	typedef logic [1:0] way_t;
	typedef logic [31:0] line_t;
	typedef logic [$clog2(TSHR_ENTRIES) - 1:0] tshr_idx_t;

	// ST_SD waits for the owner's data after a GetS hit an M line
	typedef enum logic [1:0] {ST_I, ST_S, ST_M, ST_SD} dir_state_t;
	typedef enum logic [2:0] {GETS, GETM, PUTS, PUTM, DATA} dir_msg_t;
	typedef enum logic [1:0] {FWD_NONE, FWD_GETS, FWD_GETM, FWD_INV} fwd_type_t;
	typedef enum logic [1:0] {RESP_NONE, RESP_DATA, RESP_PUT_ACK} resp_type_t;
	typedef enum logic [1:0] {SRC_TSHR, SRC_CACHE, SRC_NONE} entry_source_t;
	typedef enum logic [1:0] {DEST_REQUESTOR, DEST_OWNER, DEST_SHARERS} dest_sel_t;

	typedef struct packed {
		dir_state_t state;
		tile_mask_t sharers;
		tile_id_t   owner;
	} dir_entry_t;

	typedef struct packed {
		dir_msg_t msg_type;
		addr_t    address;
		line_t    data;
		tile_id_t source;
	} dir_message_t;

	typedef struct packed {
		dir_state_t next_state;
		logic       current_stable;
		logic       next_stable;
		logic       sharers_add_requestor;
		logic       sharers_add_owner;
		logic       sharers_clear;
		logic       sharers_remove_requestor;
		logic       owner_set_requestor;
		logic       owner_clear;
		logic       store_data;
		logic       invalidate_way;
		logic       fwd_send;
		fwd_type_t  fwd_type;
		dest_sel_t  fwd_dest;
		logic       resp_send;
		resp_type_t resp_type;
		logic       resp_has_data;
		dest_sel_t  resp_dest;
	} rom_action_t;

	typedef struct packed {
		logic       enable;
		tshr_idx_t  index;
		logic       valid;
		dir_state_t state;
		addr_t      address;
		tile_mask_t sharers;
		tile_id_t   owner;
	} tshr_update_t;

	typedef struct packed {
		logic       enable;
		logic       valid;
		set_t       set;
		way_t       way;
		tag_t       tag;
		dir_state_t state;
		tile_mask_t sharers;
		tile_id_t   owner;
		line_t      data;
	} cache_update_t;

	typedef struct packed {
		logic       valid;
		fwd_type_t  fwd_type;
		tile_id_t   source;
		addr_t      address;
		tile_mask_t destinations;
	} fwd_msg_t;

	typedef struct packed {
		logic          valid;
		resp_type_t    resp_type;
		tile_id_t      source;
		addr_t         address;
		line_t         data;
		sharer_count_t sharers_count;
		logic          has_data;
		tile_mask_t    destinations;
	} response_t;

	function automatic tag_t addr_tag(addr_t address);
		return address[ADDR_TAG_BITS + ADDR_SET_BITS + ADDR_OFFSET_BITS - 1 -: ADDR_TAG_BITS];
	endfunction

	function automatic set_t addr_set(addr_t address);
		return address[ADDR_OFFSET_BITS +: ADDR_SET_BITS];
	endfunction

endpackage

`default_nettype wire
